// File: hdl/ahb_cache_top.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module ahb_cache_top (
    input  logic                  upstream_intf,
    input  logic                  arst_n,
    input  logic [`ADDR_BITS-1:0] up_haddr,
    input  logic [1:0]            up_htrans,
    input  logic                  up_hwrite,
    input  cache_pkg::word_t      up_hwdata,
    output logic                  up_hready,
    output cache_pkg::word_t      up_hrdata,
    output logic [`ADDR_BITS-1:0] dn_haddr,
    output logic [1:0]            dn_htrans,
    output logic                  dn_hwrite,
    output cache_pkg::word_t      dn_hwdata,
    input  cache_pkg::word_t      dn_hrdata,
    input  logic                  dn_hready
);

    cache_pkg::bank_sel_t                    lk_bank;
    cache_pkg::row_t                         lk_row;
    cache_pkg::tag_t                         lk_tag;
    cache_pkg::offset_t                      lk_offset;
    logic [`BANK_COUNT-1:0]                  fill_en;
    cache_pkg::line_t                        fill_line;
    logic [`BANK_COUNT-1:0]                  upd_en;
    cache_pkg::offset_t                      upd_offset;
    cache_pkg::word_t                        upd_word;
    logic [`BANK_COUNT-1:0]                  bank_valid;
    cache_pkg::tag_t  [`BANK_COUNT-1:0]      bank_tag;
    cache_pkg::line_t [`BANK_COUNT-1:0]      bank_line;
    logic                                    hit;
    cache_pkg::word_t                        hit_word;
    logic                                    start;
    logic                                    start_write;
    logic [`ADDR_BITS-1:0]                   line_addr;
    logic [`ADDR_BITS-1:0]                   wr_addr;
    cache_pkg::word_t                        wr_word;
    logic                                    done;
    cache_pkg::line_t                        fill_data;

    transfer_handler u_handler (
        .upstream_intf (upstream_intf),
        .arst_n        (arst_n),
        .up_haddr      (up_haddr),
        .up_htrans     (up_htrans),
        .up_hwrite     (up_hwrite),
        .up_hwdata     (up_hwdata),
        .hit           (hit),
        .hit_word      (hit_word),
        .done          (done),
        .fill_data     (fill_data),
        .up_hready     (up_hready),
        .up_hrdata     (up_hrdata),
        .lk_bank       (lk_bank),
        .lk_row        (lk_row),
        .lk_tag        (lk_tag),
        .lk_offset     (lk_offset),
        .fill_en       (fill_en),
        .fill_line     (fill_line),
        .upd_en        (upd_en),
        .upd_offset    (upd_offset),
        .upd_word      (upd_word),
        .start         (start),
        .start_write   (start_write),
        .line_addr     (line_addr),
        .wr_addr       (wr_addr),
        .wr_word       (wr_word)
    );

    for (genvar g = 0; g < `BANK_COUNT; g++) begin : gen_bank
        cache_bank u_bank (
            .upstream_intf (upstream_intf),
            .arst_n        (arst_n),
            .lk_row        (lk_row),
            .fill_en       (fill_en[g]),
            .fill_tag      (lk_tag),
            .fill_line     (fill_line),
            .upd_en        (upd_en[g]),
            .upd_offset    (upd_offset),
            .upd_word      (upd_word),
            .ent_valid     (bank_valid[g]),
            .ent_tag       (bank_tag[g]),
            .ent_line      (bank_line[g])
        );
    end

    hit_collector u_collector (
        .lk_bank    (lk_bank),
        .lk_tag     (lk_tag),
        .lk_offset  (lk_offset),
        .bank_valid (bank_valid),
        .bank_tag   (bank_tag),
        .bank_line  (bank_line),
        .hit        (hit),
        .hit_word   (hit_word)
    );

    refill_engine u_refill (
        .upstream_intf (upstream_intf),
        .arst_n        (arst_n),
        .start         (start),
        .start_write   (start_write),
        .line_addr     (line_addr),
        .wr_addr       (wr_addr),
        .wr_word       (wr_word),
        .dn_hrdata     (dn_hrdata),
        .dn_hready     (dn_hready),
        .dn_haddr      (dn_haddr),
        .dn_htrans     (dn_htrans),
        .dn_hwrite     (dn_hwrite),
        .dn_hwdata     (dn_hwdata),
        .done          (done),
        .fill_data     (fill_data)
    );

endmodule

// File: hdl/cache_bank.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_bank (
    input  logic               upstream_intf,
    input  logic               arst_n,
    input  cache_pkg::row_t    lk_row,
    input  logic               fill_en,
    input  cache_pkg::tag_t    fill_tag,
    input  cache_pkg::line_t   fill_line,
    input  logic               upd_en,
    input  cache_pkg::offset_t upd_offset,
    input  cache_pkg::word_t   upd_word,
    output logic               ent_valid,
    output cache_pkg::tag_t    ent_tag,
    output cache_pkg::line_t   ent_line
);

    localparam int ROWS = 2 ** cache_pkg::ROW_BITS;

    logic [ROWS-1:0]  valid_q;
    cache_pkg::tag_t  tag_mem  [ROWS];
    cache_pkg::line_t line_mem [ROWS];

    // Lookup is combinational so a hit answers in the first data phase
    assign ent_valid = valid_q[lk_row];
    assign ent_tag   = tag_mem[lk_row];
    assign ent_line  = line_mem[lk_row];

    always_ff @(posedge upstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[lk_row] <= 1'b1;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (fill_en) begin
            tag_mem[lk_row]  <= fill_tag;
            line_mem[lk_row] <= fill_line;
        end else if (upd_en) begin
            line_mem[lk_row][upd_offset * `WORD_BITS +: `WORD_BITS] <= upd_word;  // Write hit
        end
    end

endmodule

// File: hdl/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    localparam int OFFSET_BITS = $clog2(`LINE_BITS / `WORD_BITS);
    localparam int BANK_BITS   = $clog2(`BANK_COUNT);
    localparam int ROW_BITS    = $clog2(`CACHE_BYTES * 8 / `LINE_BITS / `BANK_COUNT);
    localparam int OFFSET_LSB  = $clog2(`WORD_BITS / 8);  // Skips the byte lane bits
    localparam int BANK_LSB    = OFFSET_LSB + OFFSET_BITS;
    localparam int ROW_LSB     = BANK_LSB + BANK_BITS;
    localparam int TAG_LSB     = ROW_LSB + ROW_BITS;
    localparam int TAG_BITS    = `ADDR_BITS - TAG_LSB;

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    typedef logic [`WORD_BITS-1:0]  word_t;
    typedef logic [`LINE_BITS-1:0]  line_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [BANK_BITS-1:0]   bank_sel_t;
    typedef logic [ROW_BITS-1:0]    row_t;
    typedef logic [TAG_BITS-1:0]    tag_t;

    typedef enum logic [2:0] {
        HS_IDLE,
        HS_LOOKUP,
        HS_WAIT_FILL,
        HS_RESPOND,
        HS_WAIT_WRITE
    } handler_state_t;

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_ADDR,
        RS_DATA,
        RS_DONE
    } refill_state_t;

endpackage

// File: hdl/hit_collector.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module hit_collector (
    input  cache_pkg::bank_sel_t                 lk_bank,
    input  cache_pkg::tag_t                      lk_tag,
    input  cache_pkg::offset_t                   lk_offset,
    input  logic [`BANK_COUNT-1:0]               bank_valid,
    input  cache_pkg::tag_t  [`BANK_COUNT-1:0]   bank_tag,
    input  cache_pkg::line_t [`BANK_COUNT-1:0]   bank_line,
    output logic                                 hit,
    output cache_pkg::word_t                     hit_word
);

    logic             sel_valid;
    cache_pkg::tag_t  sel_tag;
    cache_pkg::line_t sel_line;

    always_comb begin
        sel_valid = bank_valid[lk_bank];  // Only the addressed bank can hold the line
        sel_tag   = bank_tag[lk_bank];
        sel_line  = bank_line[lk_bank];
    end

    assign hit      = sel_valid && (sel_tag == lk_tag);
    assign hit_word = sel_line[lk_offset * `WORD_BITS +: `WORD_BITS];

endmodule

// File: hdl/refill_engine.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module refill_engine (
    input  logic                  upstream_intf,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  start_write,
    input  logic [`ADDR_BITS-1:0] line_addr,
    input  logic [`ADDR_BITS-1:0] wr_addr,
    input  cache_pkg::word_t      wr_word,
    input  cache_pkg::word_t      dn_hrdata,
    input  logic                  dn_hready,
    output logic [`ADDR_BITS-1:0] dn_haddr,
    output logic [1:0]            dn_htrans,
    output logic                  dn_hwrite,
    output cache_pkg::word_t      dn_hwdata,
    output logic                  done,
    output cache_pkg::line_t      fill_data
);

    cache_pkg::refill_state_t state_q;
    cache_pkg::offset_t       beat_q;
    logic                     write_q;
    logic                     pend_q;
    logic [`ADDR_BITS-1:0]    base_q;
    cache_pkg::word_t         wdata_q;
    logic [`ADDR_BITS-1:0]    req_addr;
    logic                     req_write;
    logic                     go;
    logic                     beat_done;
    logic                     last_beat;

    assign req_addr  = start ? (start_write ? wr_addr : line_addr) : base_q;
    assign req_write = start ? start_write : write_q;

    // The address phase may only change after an edge with dn_hready high
    assign go        = (state_q == cache_pkg::RS_IDLE) && (start || pend_q) && dn_hready;
    assign beat_done = (state_q == cache_pkg::RS_DATA) && dn_hready;
    assign last_beat = write_q || (beat_q == '1);

    assign dn_htrans = (state_q == cache_pkg::RS_ADDR) ? cache_pkg::HTRANS_NONSEQ :
                       cache_pkg::HTRANS_IDLE;
    assign dn_hwdata = wdata_q;
    assign done      = (state_q == cache_pkg::RS_DONE);

    always_ff @(posedge upstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= cache_pkg::RS_IDLE;
            beat_q    <= '0;
            write_q   <= 1'b0;
            pend_q    <= 1'b0;
            dn_hwrite <= 1'b0;
        end else begin
            case (state_q)
                cache_pkg::RS_IDLE: begin
                    if (start) begin
                        write_q <= start_write;
                    end
                    if (go) begin
                        state_q   <= cache_pkg::RS_ADDR;
                        beat_q    <= '0;
                        pend_q    <= 1'b0;
                        dn_hwrite <= req_write;
                    end else if (start) begin
                        pend_q <= 1'b1;  // Held until the bus is ready
                    end
                end
                cache_pkg::RS_ADDR: begin
                    if (dn_hready) begin
                        state_q <= cache_pkg::RS_DATA;
                    end
                end
                cache_pkg::RS_DATA: begin
                    if (beat_done) begin
                        if (last_beat) begin
                            state_q <= cache_pkg::RS_DONE;
                        end else begin
                            beat_q  <= beat_q + 1'b1;
                            state_q <= cache_pkg::RS_ADDR;
                        end
                    end
                end
                default: begin
                    state_q <= cache_pkg::RS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (start) begin
            base_q  <= req_addr;
            wdata_q <= wr_word;
        end
        if (go) begin
            dn_haddr <= req_addr;
        end else if (beat_done && !last_beat) begin
            dn_haddr <= dn_haddr + `ADDR_BITS'(`WORD_BITS / 8);
        end
        if (beat_done && !write_q) begin
            fill_data <= {dn_hrdata, fill_data[`LINE_BITS-1:`WORD_BITS]};  // First beat ends lowest
        end
    end

endmodule

// File: hdl/transfer_handler.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module transfer_handler (
    input  logic                   upstream_intf,
    input  logic                   arst_n,
    input  logic [`ADDR_BITS-1:0]  up_haddr,
    input  logic [1:0]             up_htrans,
    input  logic                   up_hwrite,
    input  cache_pkg::word_t       up_hwdata,
    input  logic                   hit,
    input  cache_pkg::word_t       hit_word,
    input  logic                   done,
    input  cache_pkg::line_t       fill_data,
    output logic                   up_hready,
    output cache_pkg::word_t       up_hrdata,
    output cache_pkg::bank_sel_t   lk_bank,
    output cache_pkg::row_t        lk_row,
    output cache_pkg::tag_t        lk_tag,
    output cache_pkg::offset_t     lk_offset,
    output logic [`BANK_COUNT-1:0] fill_en,
    output cache_pkg::line_t       fill_line,
    output logic [`BANK_COUNT-1:0] upd_en,
    output cache_pkg::offset_t     upd_offset,
    output cache_pkg::word_t       upd_word,
    output logic                   start,
    output logic                   start_write,
    output logic [`ADDR_BITS-1:0]  line_addr,
    output logic [`ADDR_BITS-1:0]  wr_addr,
    output cache_pkg::word_t       wr_word
);

    cache_pkg::handler_state_t state_q;
    logic [`ADDR_BITS-1:0]     addr_q;
    logic                      write_q;
    logic                      wr_hit_q;
    cache_pkg::word_t          wdata_q;
    logic [`BANK_COUNT-1:0]    bank_onehot;
    logic                      read_hit;
    logic                      accept;

    assign lk_offset = addr_q[cache_pkg::OFFSET_LSB +: cache_pkg::OFFSET_BITS];
    assign lk_bank   = addr_q[cache_pkg::BANK_LSB +: cache_pkg::BANK_BITS];
    assign lk_row    = addr_q[cache_pkg::ROW_LSB +: cache_pkg::ROW_BITS];
    assign lk_tag    = addr_q[cache_pkg::TAG_LSB +: cache_pkg::TAG_BITS];

    assign bank_onehot = `BANK_COUNT'(1) << lk_bank;

    assign read_hit  = (state_q == cache_pkg::HS_LOOKUP) && !write_q && hit;  // Zero wait states
    assign up_hready = (state_q == cache_pkg::HS_IDLE) || (state_q == cache_pkg::HS_RESPOND) ||
                       read_hit;
    assign accept    = up_hready && (up_htrans == cache_pkg::HTRANS_NONSEQ);

    // After a refill the word comes from the assembled line
    assign up_hrdata = (state_q == cache_pkg::HS_RESPOND) ?
                       fill_data[lk_offset * `WORD_BITS +: `WORD_BITS] : hit_word;

    assign start       = (state_q == cache_pkg::HS_LOOKUP) && (write_q || !hit);
    assign start_write = write_q;
    assign line_addr   = {addr_q[`ADDR_BITS-1:cache_pkg::BANK_LSB], {cache_pkg::BANK_LSB{1'b0}}};
    assign wr_addr     = addr_q;
    assign wr_word     = up_hwdata;  // Write data is on the bus in the lookup cycle

    assign fill_en    = (state_q == cache_pkg::HS_WAIT_FILL && done) ? bank_onehot : '0;
    assign fill_line  = fill_data;
    assign upd_en     = (state_q == cache_pkg::HS_WAIT_WRITE && done && wr_hit_q) ?
                        bank_onehot : '0;
    assign upd_offset = lk_offset;
    assign upd_word   = wdata_q;

    always_ff @(posedge upstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= cache_pkg::HS_IDLE;
            write_q  <= 1'b0;
            wr_hit_q <= 1'b0;
        end else begin
            if (accept) begin
                write_q <= up_hwrite;
            end
            case (state_q)
                cache_pkg::HS_IDLE, cache_pkg::HS_RESPOND: begin
                    state_q <= accept ? cache_pkg::HS_LOOKUP : cache_pkg::HS_IDLE;
                end
                cache_pkg::HS_LOOKUP: begin
                    if (write_q) begin
                        wr_hit_q <= hit;  // Only a cached line takes the new word
                        state_q  <= cache_pkg::HS_WAIT_WRITE;
                    end else if (hit) begin
                        state_q <= accept ? cache_pkg::HS_LOOKUP : cache_pkg::HS_IDLE;
                    end else begin
                        state_q <= cache_pkg::HS_WAIT_FILL;
                    end
                end
                cache_pkg::HS_WAIT_FILL, cache_pkg::HS_WAIT_WRITE: begin
                    if (done) begin
                        state_q <= cache_pkg::HS_RESPOND;
                    end
                end
                default: begin
                    state_q <= cache_pkg::HS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (accept) begin
            addr_q <= up_haddr;
        end
        if (state_q == cache_pkg::HS_LOOKUP && write_q) begin
            wdata_q <= up_hwdata;
        end
    end

endmodule

// File: include/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Data capacity of the cache in bytes
`define CACHE_BYTES 1024

// One line is four bus words
`define LINE_BITS 128

// Banks are picked by the lowest index bits of the address
`define BANK_COUNT 4

// Bus widths on both AHB-Lite ports
`define ADDR_BITS 32
`define WORD_BITS 32

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module ahb_cache_tb \
    -o ahb_cache_sim \
    && ./obj_dir/ahb_cache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Finished with no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tests/ahb_cache_properties.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module ahb_cache_properties (
    input logic                  upstream_intf,
    input logic                  arst_n,
    input logic [`ADDR_BITS-1:0] dn_haddr,
    input logic [1:0]            dn_htrans,
    input logic                  dn_hwrite,
    input logic                  dn_hready,
    input logic                  done,
    input logic                  up_hready
);

    // An address phase held by a wait state must not move
    property dn_addr_held;
        @(posedge upstream_intf) disable iff (!arst_n)
            (dn_htrans == cache_pkg::HTRANS_NONSEQ && !dn_hready) |=>
                ($stable(dn_haddr) && $stable(dn_htrans) && $stable(dn_hwrite));
    endproperty

    property ready_after_done;
        @(posedge upstream_intf) disable iff (!arst_n)
            done |=> up_hready;
    endproperty

    dn_addr_held_check: assert property (dn_addr_held)
        else $error("Downstream address phase changed while dn_hready was low");

    ready_after_done_check: assert property (ready_after_done)
        else $error("up_hready was low in the cycle after done");

endmodule

bind ahb_cache_top ahb_cache_properties u_props (
    .upstream_intf (upstream_intf),
    .arst_n        (arst_n),
    .dn_haddr      (dn_haddr),
    .dn_htrans     (dn_htrans),
    .dn_hwrite     (dn_hwrite),
    .dn_hready     (dn_hready),
    .done          (done),
    .up_hready     (up_hready)
);

// File: tests/ahb_cache_tb.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module ahb_cache_tb;

    localparam int WAIT_LIMIT = 200;
    localparam int ROW_COUNT  = 14;

    typedef struct packed {
        logic                  wr;
        logic [`ADDR_BITS-1:0] addr;
        logic [`WORD_BITS-1:0] data;
        logic [`WORD_BITS-1:0] exp_rdata;
        logic [2:0]            exp_reads;
    } stim_row_t;

    // Columns are write flag, address, write data, expected read data, downstream reads
    stim_row_t stim_table [ROW_COUNT] = '{
        '{1'b0, 32'h0000_0104, 32'h0, 32'h5a5a_0104, 3'd4},  // Cold miss refills line 0x100
        '{1'b0, 32'h0000_0100, 32'h0, 32'h5a5a_0100, 3'd0},
        '{1'b0, 32'h0000_0108, 32'h0, 32'h5a5a_0108, 3'd0},
        '{1'b0, 32'h0000_010c, 32'h0, 32'h5a5a_010c, 3'd0},
        '{1'b1, 32'h0000_0108, 32'hdead_beef, 32'h0, 3'd0},  // Write hit
        '{1'b0, 32'h0000_0108, 32'h0, 32'hdead_beef, 3'd0},
        '{1'b1, 32'h0000_0234, 32'h1234_5678, 32'h0, 3'd0},  // Write miss must not allocate
        '{1'b0, 32'h0000_0234, 32'h0, 32'h1234_5678, 3'd4},
        '{1'b0, 32'h0000_0230, 32'h0, 32'h5a5a_0230, 3'd0},
        '{1'b0, 32'h0000_0504, 32'h0, 32'h5a5a_0504, 3'd4},  // Same bank and row, other tag
        '{1'b0, 32'h0000_0108, 32'h0, 32'hdead_beef, 3'd4},
        '{1'b0, 32'h0000_0508, 32'h0, 32'h5a5a_0508, 3'd4},
        '{1'b0, 32'h8000_0f3c, 32'h0, 32'hda5a_0f3c, 3'd4},
        '{1'b0, 32'h8000_0f30, 32'h0, 32'hda5a_0f30, 3'd0}
    };

    logic                  upstream_intf;
    logic                  arst_n;
    logic [`ADDR_BITS-1:0] up_haddr;
    logic [1:0]            up_htrans;
    logic                  up_hwrite;
    logic [`WORD_BITS-1:0] up_hwdata;
    logic                  up_hready;
    logic [`WORD_BITS-1:0] up_hrdata;
    logic [`ADDR_BITS-1:0] dn_haddr;
    logic [1:0]            dn_htrans;
    logic                  dn_hwrite;
    logic [`WORD_BITS-1:0] dn_hwdata;
    logic [`WORD_BITS-1:0] dn_hrdata = '0;
    logic                  dn_hready = 1'b1;

    logic [`WORD_BITS-1:0] mem_words [logic [`ADDR_BITS-1:0]];
    logic [`ADDR_BITS-1:0] rd_addrs [$];
    logic                  dp_active = 1'b0;
    logic                  dp_write = 1'b0;
    logic [`ADDR_BITS-1:0] dp_addr = '0;
    logic [`ADDR_BITS-1:0] last_wr_addr = '0;
    logic [`WORD_BITS-1:0] last_wr_data = '0;
    logic [31:0]           lfsr_q = 32'hac3fe5c5;
    int                    reads_total = 0;
    int                    writes_total = 0;
    int                    mismatch_count = 0;
    int                    failure_count = 0;

    ahb_cache_top UUT (
        .upstream_intf (upstream_intf),
        .arst_n        (arst_n),
        .up_haddr      (up_haddr),
        .up_htrans     (up_htrans),
        .up_hwrite     (up_hwrite),
        .up_hwdata     (up_hwdata),
        .up_hready     (up_hready),
        .up_hrdata     (up_hrdata),
        .dn_haddr      (dn_haddr),
        .dn_htrans     (dn_htrans),
        .dn_hwrite     (dn_hwrite),
        .dn_hwdata     (dn_hwdata),
        .dn_hrdata     (dn_hrdata),
        .dn_hready     (dn_hready)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    function automatic logic [`WORD_BITS-1:0] read_word(input logic [`ADDR_BITS-1:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
        mismatch_count++;
    endtask

    initial begin
        upstream_intf = 1'b0;
        forever #2 upstream_intf = ~upstream_intf;
    end

    // Memory model bookkeeping at the falling edge, where all bus signals are settled
    always @(negedge upstream_intf) begin
        if (arst_n) begin
            if (dp_active && dn_hready) begin
                if (dp_write) begin
                    mem_words[dp_addr] = dn_hwdata;
                    last_wr_addr = dp_addr;
                    last_wr_data = dn_hwdata;
                    writes_total++;
                end else begin
                    rd_addrs.push_back(dp_addr);
                    reads_total++;
                end
                dp_active = 1'b0;
            end
            if (dn_htrans == 2'b10 && dn_hready) begin
                dp_active = 1'b1;
                dp_addr = dn_haddr;
                dp_write = dn_hwrite;
            end
        end
    end

    always @(posedge upstream_intf) begin
        #1;
        lfsr_q = lfsr_step(lfsr_q);
        dn_hready = lfsr_q[0];  // Random wait states
        dn_hrdata = (dp_active && !dp_write) ? read_word(dp_addr) : '0;
    end

    task automatic run_transfer(input int idx, output logic timed_out);
        stim_row_t r;
        int waits;
        int reads_start;
        int writes_start;
        int reads_made;
        logic [`ADDR_BITS-1:0] base;
        logic [`WORD_BITS-1:0] got;
        r = stim_table[idx];
        timed_out = 1'b0;
        reads_start = reads_total;
        writes_start = writes_total;
        up_haddr = r.addr;
        up_htrans = 2'b10;
        up_hwrite = r.wr;
        @(posedge upstream_intf);
        #1;
        up_htrans = 2'b00;
        up_hwdata = r.data;
        waits = 0;
        @(negedge upstream_intf);
        while (!up_hready && waits < WAIT_LIMIT) begin
            waits++;
            @(negedge upstream_intf);
        end
        if (!up_hready) begin
            $display("Timeout at %0t: up_hready stayed low for row %0d", $time, idx);
            failure_count++;
            timed_out = 1'b1;
        end else begin
            got = up_hrdata;
            @(posedge upstream_intf);
            #1;
            reads_made = reads_total - reads_start;
            if (!r.wr && got !== r.exp_rdata) begin
                report_mismatch("up_hrdata", r.exp_rdata, got);
            end
            if (!r.wr && r.exp_reads == 0 && waits != 0) begin
                $display("Failure at %0t: row %0d hit took %0d wait states", $time, idx, waits);
                failure_count++;
            end
            if (reads_made != int'(r.exp_reads)) begin
                $display("Failure at %0t: row %0d made %0d downstream reads instead of %0d",
                         $time, idx, reads_made, r.exp_reads);
                failure_count++;
            end else if (reads_made == 4) begin
                base = r.addr & ~32'hf;
                for (int i = 0; i < 4; i++) begin
                    if (rd_addrs[reads_start + i] !== base + 32'(4 * i)) begin
                        report_mismatch("dn_haddr", base + 32'(4 * i), rd_addrs[reads_start + i]);
                    end
                end
            end
            if (writes_total - writes_start != (r.wr ? 1 : 0)) begin
                $display("Failure at %0t: row %0d made %0d downstream writes", $time, idx,
                         writes_total - writes_start);
                failure_count++;
            end else if (r.wr) begin
                if (last_wr_addr !== r.addr) begin
                    report_mismatch("dn_haddr", r.addr, last_wr_addr);
                end
                if (last_wr_data !== r.data) begin
                    report_mismatch("dn_hwdata", r.data, last_wr_data);
                end
            end
        end
    endtask

    initial begin
        logic timed_out;
        arst_n = 1'b0;
        up_haddr = '0;
        up_htrans = 2'b00;
        up_hwrite = 1'b0;
        up_hwdata = '0;
        timed_out = 1'b0;
        repeat (16) @(posedge upstream_intf);
        #1;
        arst_n = 1'b1;
        if (up_hready !== 1'b1) begin
            report_mismatch("up_hready", 32'd1, {31'd0, up_hready});
        end
        if (dn_htrans !== 2'b00) begin
            report_mismatch("dn_htrans", 32'd0, {30'd0, dn_htrans});
        end
        for (int i = 0; i < ROW_COUNT && !timed_out; i++) begin
            run_transfer(i, timed_out);
        end
        $display("Checks done with %0d mismatches and %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/cache_pkg.sv
hdl/hit_collector.sv
hdl/cache_bank.sv
hdl/refill_engine.sv
hdl/transfer_handler.sv
hdl/ahb_cache_top.sv
tests/ahb_cache_properties.sv
tests/ahb_cache_tb.sv
